//--- sim/gw_patterns.hex
// One weight byte per line, in stream address order 0 to 57
// Segments: W1 at 0, A1 at 32, W2 at 40, A2 at 52
5b
80
a5
ca
ef
14
39
5e
83
a8
cd
f2
17
3c
61
86
ab
d0
f5
1a
3f
64
89
ae
d3
f8
1d
42
67
8c
b1
d6
fb
20
45
6a
8f
b4
d9
fe
23
48
6d
92
b7
dc
01
26
4b
70
95
ba
df
04
29
4e
73
98

//--- gat_wgt_scheduler.f
+incdir+logic
logic/gw_pkg.sv
logic/wgt_stream_seq.sv
logic/wgt_col_banks.sv
logic/attn_vec_capture.sv
logic/conv2_wgt_capture.sv
logic/gat_wgt_scheduler.sv
sim/gat_wgt_scheduler_assert.sv
sim/gat_wgt_scheduler_tb.sv

//--- Bender.yml
package:
  name: gat_wgt_scheduler

sources:
  - include_dirs:
      - logic
    files:
      - logic/gw_pkg.sv
      - logic/wgt_stream_seq.sv
      - logic/wgt_col_banks.sv
      - logic/attn_vec_capture.sv
      - logic/conv2_wgt_capture.sv
      - logic/gat_wgt_scheduler.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/gat_wgt_scheduler_assert.sv
      - sim/gat_wgt_scheduler_tb.sv

//--- sim/gat_wgt_scheduler_tb.sv
// Testbench for the weight loader; streams the pattern file through the DUT and checks every capture
`timescale 1ns/1ps
`include "gw_settings.svh"

module gat_wgt_scheduler_tb;

  localparam int RESET_CYCLES    = 5;
  localparam int WATCHDOG_CYCLES = (gw_pkg::TOTAL_WORDS * 4 + RESET_CYCLES) * 2;

  logic                                                 clk;
  logic                                                 rst_n;
  logic                                                 fetch_en;
  gw_pkg::word_t                                        wgt_rd_data;
  gw_pkg::addr_t                                        wgt_addr;
  logic [`GW_FEAT_OUT-1:0][gw_pkg::ROW_W-1:0]           col_rd_addr;
  gw_pkg::word_t [`GW_FEAT_OUT-1:0]                     col_rd_data;
  gw_pkg::word_t [gw_pkg::A1_LEN-1:0]                   attn1;
  gw_pkg::word_t [gw_pkg::A2_LEN-1:0]                   attn2;
  gw_pkg::word_t [`GW_FEAT_FINAL-1:0][`GW_FEAT_OUT-1:0] w2;
  logic                                                 ready;

  gw_pkg::word_t pattern_mem [gw_pkg::TOTAL_WORDS];
  logic [31:0]   rng_state;
  int            errors;
  int            checks;
  logic          done_load;

  // Monitor state sampled on the falling edge
  logic          prev_valid;
  gw_pkg::addr_t prev_addr;
  logic          prev_en;
  logic          prev_ready;
  gw_pkg::addr_t exp_addr;
  int            ready_wait;
  logic          late_reported;

  gat_wgt_scheduler u_gat_wgt_scheduler (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en),
    .wgt_rd_data_i (wgt_rd_data),
    .wgt_addr_o    (wgt_addr),
    .col_rd_addr_i (col_rd_addr),
    .col_rd_data_o (col_rd_data),
    .attn1_o       (attn1),
    .attn2_o       (attn2),
    .w2_o          (w2),
    .ready_o       (ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // External weight memory with one cycle read latency
  always @(posedge clk) begin
    if (wgt_addr < gw_pkg::TOTAL_WORDS) begin
      wgt_rd_data <= pattern_mem[wgt_addr];
    end else begin
      wgt_rd_data <= '0;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_word(input string name, input gw_pkg::word_t got,
                              input gw_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ====================================================================
  // Address walk and ready level
  // ====================================================================

  always @(negedge clk) begin
    if (!rst_n) begin
      prev_valid    = 1'b0;
      ready_wait    = 0;
      late_reported = 1'b0;
    end else begin
      if (prev_valid) begin
        exp_addr = prev_addr;
        if (prev_en && (prev_addr < gw_pkg::TOTAL_WORDS)) begin
          exp_addr = prev_addr + 1'b1;
        end
        checks++;
        if (wgt_addr !== exp_addr) begin
          errors++;
          $display("Mismatch at %0t: wgt_addr_o got %0d expected %0d",
                   $time, wgt_addr, exp_addr);
        end
        if (prev_ready && (ready !== 1'b1)) begin
          errors++;
          $display("Error at %0t: ready_o fell after it had risen", $time);
        end
      end
      if (wgt_addr < gw_pkg::TOTAL_WORDS) begin
        checks++;
        if (ready !== 1'b0) begin
          errors++;
          $display("Mismatch at %0t: ready_o got %b expected 0 at wgt_addr_o %0d",
                   $time, ready, wgt_addr);
        end
      end else if (ready !== 1'b1) begin
        ready_wait++;
        if ((ready_wait > 2) && !late_reported) begin
          errors++;
          late_reported = 1'b1;
          $display("Error at %0t: ready_o did not rise within two cycles of the last address",
                   $time);
        end
      end
      prev_addr  = wgt_addr;
      prev_en    = fetch_en;
      prev_ready = ready;
      prev_valid = 1'b1;
    end
  end

  // ====================================================================
  // Readback after ready
  // ====================================================================

  task automatic check_col_banks();
    for (int row = 0; row < `GW_FEAT_IN; row++) begin
      @(posedge clk);
      for (int c = 0; c < `GW_FEAT_OUT; c++) begin
        col_rd_addr[c] <= row[gw_pkg::ROW_W-1:0];
      end
      @(posedge clk);
      @(negedge clk);
      for (int c = 0; c < `GW_FEAT_OUT; c++) begin
        compare_word($sformatf("col_rd_data_o[%0d] row %0d", c, row), col_rd_data[c],
                     pattern_mem[row * `GW_FEAT_OUT + c]);
      end
    end
  endtask

  task automatic check_registers();
    @(negedge clk);
    for (int i = 0; i < gw_pkg::A1_LEN; i++) begin
      compare_word($sformatf("attn1_o[%0d]", i), attn1[i], pattern_mem[gw_pkg::A1_BASE + i]);
    end
    for (int i = 0; i < gw_pkg::A2_LEN; i++) begin
      compare_word($sformatf("attn2_o[%0d]", i), attn2[i], pattern_mem[gw_pkg::A2_BASE + i]);
    end
    // Transposed layout puts output feature c in column c
    for (int c = 0; c < `GW_FEAT_FINAL; c++) begin
      for (int r = 0; r < `GW_FEAT_OUT; r++) begin
        compare_word($sformatf("w2_o[%0d][%0d]", c, r), w2[c][r],
                     pattern_mem[gw_pkg::W2_BASE + r * `GW_FEAT_FINAL + c]);
      end
    end
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial begin
    rst_n       = 1'b0;
    fetch_en    = 1'b0;
    wgt_rd_data = '0;
    col_rd_addr = '0;
    rng_state   = 32'haa9;
    errors      = 0;
    checks      = 0;
    done_load   = 1'b0;
    $readmemh("sim/gw_patterns.hex", pattern_mem);
    if (pattern_mem[gw_pkg::TOTAL_WORDS-1] === 'x) begin
      errors++;
      $display("Error: pattern file sim/gw_patterns.hex was not read completely");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Roughly one cycle in four with enable low
    while (!done_load) begin
      @(posedge clk);
      rng_state = xorshift32(rng_state);
      fetch_en <= (rng_state[1:0] != 2'b00);
      @(negedge clk);
      done_load = ready;
    end
    // Enable stays high so the walk is seen to stop at the last address
    @(posedge clk);
    fetch_en <= 1'b1;

    check_col_banks();
    check_registers();

    errors += u_gat_wgt_scheduler.u_seq.u_seq_assert.fail_count;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: run did not finish within %0d cycles, errors so far: %0d",
             WATCHDOG_CYCLES, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- sim/gat_wgt_scheduler_assert.sv
// Concurrent checks on the stream sequencer that bind into every wgt_stream_seq instance
`timescale 1ns/1ps

module gat_wgt_scheduler_assert (
  input logic          clk,
  input logic          rst_n,
  input logic          fetch_en_i,
  input gw_pkg::addr_t wgt_addr_o,
  input logic          col_we_o,
  input logic          a1_we_o,
  input logic          w2_we_o,
  input logic          a2_we_o,
  input logic          ready_o
);

  int fail_count = 0;

  // ====================================================================
  // Sequencer properties
  // ====================================================================

  // One strobe for each word issued on the previous cycle and none otherwise
  strobe_per_word: assert property (@(posedge clk) disable iff (!rst_n)
    $countones({col_we_o, a1_we_o, w2_we_o, a2_we_o}) ==
      (($past(fetch_en_i) && ($past(wgt_addr_o) < gw_pkg::TOTAL_WORDS)) ? 1 : 0))
    else begin
      fail_count++;
      $error("Capture strobes do not match the words issued");
    end

  addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_addr_o <= gw_pkg::TOTAL_WORDS)
    else begin
      fail_count++;
      $error("Address beyond the end of the weight stream");
    end

  addr_holds: assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_en_i |=> $stable(wgt_addr_o))
    else begin
      fail_count++;
      $error("Address moved while enable was low");
    end

  ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    ready_o |=> ready_o)
    else begin
      fail_count++;
      $error("Ready level dropped before reset");
    end

endmodule

bind wgt_stream_seq gat_wgt_scheduler_assert u_seq_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .fetch_en_i (fetch_en_i),
  .wgt_addr_o (wgt_addr_o),
  .col_we_o   (col_we_o),
  .a1_we_o    (a1_we_o),
  .w2_we_o    (w2_we_o),
  .a2_we_o    (a2_we_o),
  .ready_o    (ready_o)
);

//--- logic/gat_wgt_scheduler.sv
// Weight loader top level; streams the packed weight memory into column banks and registers
`timescale 1ns/1ps
`include "gw_settings.svh"

module gat_wgt_scheduler (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 fetch_en_i,
  input  gw_pkg::word_t                                        wgt_rd_data_i,
  output gw_pkg::addr_t                                        wgt_addr_o,
  input  logic [`GW_FEAT_OUT-1:0][gw_pkg::ROW_W-1:0]           col_rd_addr_i,
  output gw_pkg::word_t [`GW_FEAT_OUT-1:0]                     col_rd_data_o,
  output gw_pkg::word_t [gw_pkg::A1_LEN-1:0]                   attn1_o,
  output gw_pkg::word_t [gw_pkg::A2_LEN-1:0]                   attn2_o,
  output gw_pkg::word_t [`GW_FEAT_FINAL-1:0][`GW_FEAT_OUT-1:0] w2_o,
  output logic                                                 ready_o
);

  logic          col_we;
  logic          a1_we;
  logic          w2_we;
  logic          a2_we;
  gw_pkg::addr_t elem_idx;

  // ====================================================================
  // Stream sequencer
  // ====================================================================

  wgt_stream_seq u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_en_i (fetch_en_i),
    .wgt_addr_o (wgt_addr_o),
    .col_we_o   (col_we),
    .a1_we_o    (a1_we),
    .w2_we_o    (w2_we),
    .a2_we_o    (a2_we),
    .elem_idx_o (elem_idx),
    .ready_o    (ready_o)
  );

  // ====================================================================
  // Capture blocks, all fed by the returned word
  // ====================================================================

  wgt_col_banks u_col_banks (
    .clk        (clk),
    .rst_n      (rst_n),
    .we_i       (col_we),
    .elem_idx_i (elem_idx),
    .wr_data_i  (wgt_rd_data_i),
    .rd_addr_i  (col_rd_addr_i),
    .rd_data_o  (col_rd_data_o)
  );

  attn_vec_capture #(
    .LEN (gw_pkg::A1_LEN)
  ) u_attn1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .we_i       (a1_we),
    .elem_idx_i (elem_idx),
    .wr_data_i  (wgt_rd_data_i),
    .vec_o      (attn1_o)
  );

  conv2_wgt_capture u_w2 (
    .clk        (clk),
    .rst_n      (rst_n),
    .we_i       (w2_we),
    .elem_idx_i (elem_idx),
    .wr_data_i  (wgt_rd_data_i),
    .w2_o       (w2_o)
  );

  attn_vec_capture #(
    .LEN (gw_pkg::A2_LEN)
  ) u_attn2 (
    .clk        (clk),
    .rst_n      (rst_n),
    .we_i       (a2_we),
    .elem_idx_i (elem_idx),
    .wr_data_i  (wgt_rd_data_i),
    .vec_o      (attn2_o)
  );

endmodule

//--- logic/conv2_wgt_capture.sv
// Captures layer-2 weights transposed so each output feature holds one contiguous weight vector
`timescale 1ns/1ps
`include "gw_settings.svh"

module conv2_wgt_capture (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              we_i,
  input  gw_pkg::addr_t                                     elem_idx_i,
  input  gw_pkg::word_t                                     wr_data_i,
  output gw_pkg::word_t [`GW_FEAT_FINAL-1:0][`GW_FEAT_OUT-1:0] w2_o
);

  gw_pkg::word_t [`GW_FEAT_FINAL-1:0][`GW_FEAT_OUT-1:0] w2_q;
  gw_pkg::addr_t wr_row;
  gw_pkg::addr_t wr_col;

  // ====================================================================
  // Row and column decode
  // ====================================================================

  // Stream is row-major over FEAT_OUT rows of FEAT_FINAL columns
  assign wr_row = gw_pkg::addr_t'(elem_idx_i / `GW_FEAT_FINAL);
  assign wr_col = gw_pkg::addr_t'(elem_idx_i % `GW_FEAT_FINAL);

  // Stored as [column][row]
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w2_q <= '0;
    end else if (we_i) begin
      for (int c = 0; c < `GW_FEAT_FINAL; c++) begin
        for (int r = 0; r < `GW_FEAT_OUT; r++) begin
          if ((wr_col == c) && (wr_row == r)) begin
            w2_q[c][r] <= wr_data_i;
          end
        end
      end
    end
  end

  assign w2_o = w2_q;

endmodule

//--- logic/attn_vec_capture.sv
// Register file that captures one attention vector in stream order; instantiated once per layer
`timescale 1ns/1ps

module attn_vec_capture #(
  parameter int LEN = 8
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  gw_pkg::addr_t            elem_idx_i,
  input  gw_pkg::word_t            wr_data_i,
  output gw_pkg::word_t [LEN-1:0]  vec_o
);

  gw_pkg::word_t [LEN-1:0] vec_q;

  // ====================================================================
  // Slot capture
  // ====================================================================

  // Attention words arrive in vector order, so the offset is the slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_q <= '0;
    end else if (we_i) begin
      for (int i = 0; i < LEN; i++) begin
        if (elem_idx_i == i) begin
          vec_q[i] <= wr_data_i;
        end
      end
    end
  end

  assign vec_o = vec_q;

endmodule

//--- logic/wgt_col_banks.sv
// Layer-1 weights split into one memory per output column, each with its own read port
`timescale 1ns/1ps
`include "gw_settings.svh"

module wgt_col_banks (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       we_i,
  input  gw_pkg::addr_t                              elem_idx_i,
  input  gw_pkg::word_t                              wr_data_i,
  input  logic [`GW_FEAT_OUT-1:0][gw_pkg::ROW_W-1:0] rd_addr_i,
  output gw_pkg::word_t [`GW_FEAT_OUT-1:0]           rd_data_o
);

  gw_pkg::addr_t             wr_row;
  gw_pkg::addr_t             wr_col;
  logic [gw_pkg::ROW_W-1:0]  wr_row_idx;

  // ====================================================================
  // Write decode
  // ====================================================================

  // Row-major stream, so consecutive words walk across the columns
  assign wr_row     = gw_pkg::addr_t'(elem_idx_i / `GW_FEAT_OUT);
  assign wr_col     = gw_pkg::addr_t'(elem_idx_i % `GW_FEAT_OUT);
  assign wr_row_idx = wr_row[gw_pkg::ROW_W-1:0];

  // ====================================================================
  // Column memories
  // ====================================================================

  for (genvar c = 0; c < `GW_FEAT_OUT; c++) begin : g_col
    gw_pkg::word_t col_mem [`GW_FEAT_IN];
    gw_pkg::word_t rd_q;
    logic          col_we;

    assign col_we = we_i && (wr_col == c);

    always_ff @(posedge clk) begin
      if (col_we) begin
        col_mem[wr_row_idx] <= wr_data_i;
      end
    end

    // One cycle read latency for the multiplier array
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_q <= '0;
      end else begin
        rd_q <= col_mem[rd_addr_i[c]];
      end
    end

    assign rd_data_o[c] = rd_q;
  end

endmodule

//--- logic/wgt_stream_seq.sv
// Address walker for the weight stream; issues one strobe per returned word to the capture blocks
`timescale 1ns/1ps

module wgt_stream_seq (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          fetch_en_i,
  output gw_pkg::addr_t wgt_addr_o,
  output logic          col_we_o,
  output logic          a1_we_o,
  output logic          w2_we_o,
  output logic          a2_we_o,
  output gw_pkg::addr_t elem_idx_o,
  output logic          ready_o
);

  gw_pkg::addr_t  addr_q;
  gw_pkg::addr_t  addr_nxt;
  gw_pkg::phase_e phase_q;
  gw_pkg::phase_e phase_d;
  gw_pkg::addr_t  seg_base;
  logic           advance;

  logic           col_we_q;
  logic           a1_we_q;
  logic           w2_we_q;
  logic           a2_we_q;
  gw_pkg::addr_t  elem_idx_q;
  logic           ready_q;

  // ====================================================================
  // Address walk
  // ====================================================================

  // Enable is the only back-pressure; stop once the last word is issued
  assign advance  = fetch_en_i && (addr_q < gw_pkg::TOTAL_WORDS);
  assign addr_nxt = addr_q + 1'b1;

  // Phase switches when the next address crosses a segment base
  always_comb begin
    phase_d = phase_q;
    if (advance) begin
      case (addr_nxt)
        gw_pkg::A1_BASE:     phase_d = gw_pkg::PH_A1;
        gw_pkg::W2_BASE:     phase_d = gw_pkg::PH_W2;
        gw_pkg::A2_BASE:     phase_d = gw_pkg::PH_A2;
        gw_pkg::TOTAL_WORDS: phase_d = gw_pkg::PH_DONE;
        default:             phase_d = phase_q;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q  <= '0;
      phase_q <= gw_pkg::PH_W1;
    end else begin
      if (advance) begin
        addr_q <= addr_nxt;
      end
      phase_q <= phase_d;
    end
  end

  // ====================================================================
  // Strobes, one cycle behind the issued address
  // ====================================================================

  always_comb begin
    case (phase_q)
      gw_pkg::PH_A1: seg_base = gw_pkg::addr_t'(gw_pkg::A1_BASE);
      gw_pkg::PH_W2: seg_base = gw_pkg::addr_t'(gw_pkg::W2_BASE);
      gw_pkg::PH_A2: seg_base = gw_pkg::addr_t'(gw_pkg::A2_BASE);
      default:       seg_base = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_we_q <= 1'b0;
      a1_we_q  <= 1'b0;
      w2_we_q  <= 1'b0;
      a2_we_q  <= 1'b0;
    end else begin
      col_we_q <= advance && (phase_q == gw_pkg::PH_W1);
      a1_we_q  <= advance && (phase_q == gw_pkg::PH_A1);
      w2_we_q  <= advance && (phase_q == gw_pkg::PH_W2);
      a2_we_q  <= advance && (phase_q == gw_pkg::PH_A2);
    end
  end

  // Offset within the segment, only looked at with a strobe
  always_ff @(posedge clk) begin
    if (advance) begin
      elem_idx_q <= addr_q - seg_base;
    end
  end

  // Last attention word closes the stream, all earlier segments done by then
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q <= 1'b0;
    end else if (a2_we_q && (elem_idx_q == gw_pkg::A2_LEN - 1)) begin
      ready_q <= 1'b1;
    end
  end

  assign wgt_addr_o = addr_q;
  assign col_we_o   = col_we_q;
  assign a1_we_o    = a1_we_q;
  assign w2_we_o    = w2_we_q;
  assign a2_we_o    = a2_we_q;
  assign elem_idx_o = elem_idx_q;
  assign ready_o    = ready_q;

endmodule

//--- logic/gw_pkg.sv
// Shared types and segment layout of the packed weight memory; compile ahead of the loader RTL
`include "gw_settings.svh"

package gw_pkg;

  // Segment lengths in words
  localparam int W1_WORDS = `GW_FEAT_IN * `GW_FEAT_OUT;
  localparam int A1_LEN   = 2 * `GW_FEAT_OUT;
  localparam int W2_WORDS = `GW_FEAT_OUT * `GW_FEAT_FINAL;
  localparam int A2_LEN   = 2 * `GW_FEAT_FINAL;

  // Segment start addresses, stored back to back
  localparam int A1_BASE     = W1_WORDS;
  localparam int W2_BASE     = A1_BASE + A1_LEN;
  localparam int A2_BASE     = W2_BASE + W2_WORDS;
  localparam int TOTAL_WORDS = A2_BASE + A2_LEN;

  // Address must also hold the end value TOTAL_WORDS
  localparam int ADDR_W = $clog2(TOTAL_WORDS + 1);
  localparam int ROW_W  = $clog2(`GW_FEAT_IN);

  typedef logic [`GW_DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0]     addr_t;

  // Segment that the current address falls in
  typedef enum logic [2:0] {PH_W1, PH_A1, PH_W2, PH_A2, PH_DONE} phase_e;

endpackage

//--- logic/gw_settings.svh
// Size settings for the weight loader; include wherever the feature counts or word width are needed
`ifndef GW_SETTINGS_SVH
`define GW_SETTINGS_SVH

// ====================================================================
// Word format
// ====================================================================

// Width of one weight word in the packed memory
`define GW_DATA_W      8

// ====================================================================
// Feature counts
// ====================================================================

// Layer-1 input features, also the number of weight rows
`define GW_FEAT_IN     8

// Layer-1 output features, one column memory each
`define GW_FEAT_OUT    4

// Layer-2 output features
`define GW_FEAT_FINAL  3

`endif
